/* design/audio_sample_pkg.sv */
// Audio sample definitions
`default_nettype none

package audio_sample_pkg;

    // Width of one audio sample in bits.
    localparam int SAMPLE_WIDTH = 16;

    // Signed audio sample as it travels between the voices and the mixer.
    typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

    // Supply voltage of the 555 expressed in sample units.
    localparam int VCC_LEVEL = 16384;

    // Value a voice outputs while its 555 output pin is high.
    localparam int HIGH_LEVEL = VCC_LEVEL;

    // Largest usable control voltage.
    // It must stay below VCC_LEVEL or the high-time formula divides by zero.
    localparam int CV_MAX = 16382;

    // Command opcodes understood by the control-voltage decoder.
    typedef enum logic [1:0] {
        CV_SET     = 2'd0,
        CV_MUTE    = 2'd1,
        CV_UNMUTE  = 2'd2,
        CV_ALL_OFF = 2'd3
    } cv_op_e;

endpackage

`default_nettype wire

/* design/rc_timing_pkg.sv */
// RC timing fixed-point format
`default_nettype none

package rc_timing_pkg;

    // Natural log of two, scaled by 2^16.
    localparam int LN2_Q16 = 45426;

    // The timing capacitor is given in farads scaled by 2^35.
    localparam int CAP_SHIFT = 35;

    // Fraction bits on both sides of the logarithm unit.
    localparam int LOG_FRAC_BITS = 8;

    // Width of the logarithm argument.
    localparam int LOG_IN_WIDTH = 24;

    // Width of the logarithm result.
    localparam int LOG_OUT_WIDTH = 12;

    // Width of the oscillator cycle counters.
    // 40 bits covers periods of several seconds at a 50 MHz clock.
    localparam int COUNT_WIDTH = 40;

endpackage

`default_nettype wire

/* design/natural_log.sv */
// Fixed-point natural logarithm
`timescale 1ns/1ps
`default_nettype none

module natural_log (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic [rc_timing_pkg::LOG_IN_WIDTH-1:0]  arg,
    output logic [rc_timing_pkg::LOG_OUT_WIDTH-1:0] ln_out
);

    localparam int IN_W  = rc_timing_pkg::LOG_IN_WIDTH;
    localparam int OUT_W = rc_timing_pkg::LOG_OUT_WIDTH;
    localparam int FRAC  = rc_timing_pkg::LOG_FRAC_BITS;
    // Shift that turns the Q16 ln(2) product into the Q8 result format.
    localparam int LN2_TO_OUT = 16 - FRAC;

    logic [4:0]      lead_pos;
    logic [4:0]      log2_int;
    logic [IN_W-1:0] norm;
    logic [3:0]      mant;
    logic [7:0]      mant_ln;
    logic [23:0]     int_ln_q16;

    // Position of the most significant set bit of the argument.
    always_comb begin
        lead_pos = '0;
        for (int i = 0; i < IN_W; i++) begin
            if (arg[i]) begin
                lead_pos = 5'(i);
            end
        end
    end

    // Integer part of log2, valid whenever the argument is at least 1.0.
    assign log2_int = lead_pos - 5'(FRAC);

    // Move the leading one to the top so the next four bits form the mantissa index.
    assign norm = arg << (5'(IN_W - 1) - lead_pos);
    assign mant = norm[IN_W-2 -: 4];

    // ln(1 + m/16) in Q8 for the mantissa index m.
    always_comb begin
        case (mant)
            4'd0:    mant_ln = 8'd0;
            4'd1:    mant_ln = 8'd16;
            4'd2:    mant_ln = 8'd30;
            4'd3:    mant_ln = 8'd44;
            4'd4:    mant_ln = 8'd57;
            4'd5:    mant_ln = 8'd70;
            4'd6:    mant_ln = 8'd82;
            4'd7:    mant_ln = 8'd93;
            4'd8:    mant_ln = 8'd104;
            4'd9:    mant_ln = 8'd114;
            4'd10:   mant_ln = 8'd124;
            4'd11:   mant_ln = 8'd134;
            4'd12:   mant_ln = 8'd143;
            4'd13:   mant_ln = 8'd152;
            4'd14:   mant_ln = 8'd161;
            default: mant_ln = 8'd169;
        endcase
    end

    // ln(x) = log2(x) * ln(2), carried in Q16 before dropping to Q8.
    assign int_ln_q16 = 24'(log2_int) * 24'(rc_timing_pkg::LN2_Q16);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ln_out <= '0;
        end else if (arg[IN_W-1:FRAC] == '0) begin
            // Arguments below 1.0 would give a negative log, which the timing never needs.
            ln_out <= '0;
        end else begin
            ln_out <= OUT_W'(int_ln_q16 >> LN2_TO_OUT) + OUT_W'(mant_ln);
        end
    end

endmodule

`default_nettype wire

/* design/astable_555_vco.sv */
// Astable 555 voltage-controlled oscillator
`timescale 1ns/1ps
`default_nettype none

module astable_555_vco #(
    parameter int CLOCK_RATE   = 50000000,
    parameter int R1           = 47000,
    parameter int R2           = 27000,
    parameter int C_35_SHIFTED = 1134
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      sample_en,
    input  audio_sample_pkg::sample_t v_control,
    output audio_sample_pkg::sample_t wave_out,
    output logic                      gate
);

    localparam int IN_W  = rc_timing_pkg::LOG_IN_WIDTH;
    localparam int OUT_W = rc_timing_pkg::LOG_OUT_WIDTH;
    localparam int FRAC  = rc_timing_pkg::LOG_FRAC_BITS;
    localparam int CW    = rc_timing_pkg::COUNT_WIDTH;
    localparam int V_W   = 15;

    // The high time is C*(R1+R2)*ln(...)*f with C in Q35 and ln in Q8.
    localparam int          HIGH_SHIFT = rc_timing_pkg::CAP_SHIFT + FRAC;
    localparam logic [63:0] C_R1_R2    = 64'(C_35_SHIFTED) * 64'(R1 + R2);

    // The low time is C*R2*ln(2)*f with ln(2) in Q16.
    // Part of the scaling is dropped early so the product with the clock rate fits 64 bits.
    localparam int          LOW_PRE_SHIFT = 24;
    localparam logic [63:0] C_R2_LN2      = (64'(C_35_SHIFTED) * 64'(R2) *
                                             64'(rc_timing_pkg::LN2_Q16)) >> LOW_PRE_SHIFT;
    localparam int          LOW_SHIFT     = rc_timing_pkg::CAP_SHIFT + 16 - LOW_PRE_SHIFT;
    localparam logic [CW-1:0] CYCLES_LOW  = CW'((C_R2_LN2 * 64'(CLOCK_RATE)) >> LOW_SHIFT);

    logic [V_W-1:0]   v_safe;
    logic [IN_W-1:0]  log_num;
    logic [IN_W-1:0]  log_den;
    logic [IN_W-1:0]  log_arg;
    logic [OUT_W-1:0] ln_val;
    logic [CW-1:0]    cycles_high;
    logic [CW-1:0]    wave_len;
    logic [CW-1:0]    count;
    logic             gate_next;

    // Keep the control voltage inside 0 .. CV_MAX so the divisor below is never zero.
    always_comb begin
        if (v_control < 0) begin
            v_safe = '0;
        end else if (v_control > audio_sample_pkg::CV_MAX) begin
            v_safe = V_W'(audio_sample_pkg::CV_MAX);
        end else begin
            v_safe = v_control[V_W-1:0];
        end
    end

    // Log argument 1 + v / (2 * (VCC - v)) in Q8.
    assign log_num = IN_W'(v_safe) << FRAC;
    assign log_den = (IN_W'(audio_sample_pkg::VCC_LEVEL) - IN_W'(v_safe)) << 1;

    natural_log natural_log_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .arg    (log_arg),
        .ln_out (ln_val)
    );

    // Stage 1 registers the log argument, stage 3 the high cycle count.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            log_arg     <= '0;
            cycles_high <= '0;
        end else begin
            log_arg     <= (IN_W'(1) << FRAC) + log_num / log_den;
            cycles_high <= CW'((C_R1_R2 * 64'(ln_val) * 64'(CLOCK_RATE)) >> HIGH_SHIFT);
        end
    end

    assign wave_len = cycles_high + CYCLES_LOW;

    // Output is high for the first part of the period, like the capacitor charging.
    assign gate_next = (count < cycles_high);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count    <= '0;
            gate     <= 1'b0;
            wave_out <= '0;
        end else begin
            // Greater-or-equal also recovers when a new voltage shortens the period.
            if (count >= wave_len - 1'b1) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
            if (sample_en) begin
                gate     <= gate_next;
                wave_out <= gate_next ? audio_sample_pkg::sample_t'(audio_sample_pkg::HIGH_LEVEL)
                                      : '0;
            end
        end
    end

endmodule

`default_nettype wire

/* design/cv_command_decoder.sv */
// Control-voltage command decoder
`timescale 1ns/1ps
`default_nettype none

module cv_command_decoder #(
    parameter int NUM_VOICES = 4
) (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  logic                                       cmd_strobe,
    input  audio_sample_pkg::cv_op_e                   cmd_op,
    input  logic [$clog2(NUM_VOICES):0]                cmd_voice,
    input  audio_sample_pkg::sample_t                  cmd_value,
    output audio_sample_pkg::sample_t [NUM_VOICES-1:0] cv_bus,
    output logic [NUM_VOICES-1:0]                      voice_enable
);

    // One bit wider than a plain index so that out-of-range voices can be seen and dropped.
    localparam int VOICE_W = $clog2(NUM_VOICES) + 1;

    audio_sample_pkg::sample_t set_value;

    // A 555 cannot take a negative control voltage, so those become zero.
    assign set_value = (cmd_value < 0) ? '0 : cmd_value;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cv_bus       <= '0;
            voice_enable <= '0;
        end else if (cmd_strobe) begin
            case (cmd_op)
                audio_sample_pkg::CV_SET: begin
                    // Only a matching voice is written, so larger indices do nothing.
                    for (int i = 0; i < NUM_VOICES; i++) begin
                        if (cmd_voice == VOICE_W'(i)) begin
                            cv_bus[i] <= set_value;
                        end
                    end
                end
                audio_sample_pkg::CV_MUTE: begin
                    for (int i = 0; i < NUM_VOICES; i++) begin
                        if (cmd_voice == VOICE_W'(i)) begin
                            voice_enable[i] <= 1'b0;
                        end
                    end
                end
                audio_sample_pkg::CV_UNMUTE: begin
                    for (int i = 0; i < NUM_VOICES; i++) begin
                        if (cmd_voice == VOICE_W'(i)) begin
                            voice_enable[i] <= 1'b1;
                        end
                    end
                end
                default: begin
                    // CV_ALL_OFF mutes the whole bank but leaves the voltages alone.
                    voice_enable <= '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/voice_mixer.sv */
// Voice averaging mixer
`timescale 1ns/1ps
`default_nettype none

module voice_mixer #(
    parameter int NUM_VOICES = 4
) (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  logic                                       sample_en,
    input  audio_sample_pkg::sample_t [NUM_VOICES-1:0] voice_bus,
    input  logic [NUM_VOICES-1:0]                      voice_enable,
    output audio_sample_pkg::sample_t                  mix_out
);

    // NUM_VOICES is a power of two, so the average is a plain shift.
    localparam int AVG_SHIFT = $clog2(NUM_VOICES);
    // The sum of all voices needs AVG_SHIFT extra bits; one more is kept as headroom.
    localparam int SUM_W     = audio_sample_pkg::SAMPLE_WIDTH + AVG_SHIFT + 1;

    logic                    sample_en_d;
    logic signed [SUM_W-1:0] sum;

    // Each voice registers its sample on sample_en.
    // The mixer therefore waits one cycle before it takes the new values.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sample_en_d <= 1'b0;
        end else begin
            sample_en_d <= sample_en;
        end
    end

    // Sum only the voices that are not muted.
    always_comb begin
        sum = '0;
        for (int i = 0; i < NUM_VOICES; i++) begin
            if (voice_enable[i]) begin
                sum = sum + SUM_W'(voice_bus[i]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mix_out <= '0;
        end else if (sample_en_d) begin
            // Dividing by the voice count keeps the full bank inside one sample range.
            mix_out <= audio_sample_pkg::sample_t'(sum >>> AVG_SHIFT);
        end
    end

endmodule

`default_nettype wire

/* design/vco_bank_top.sv */
// Bank of 555 oscillators
`timescale 1ns/1ps
`default_nettype none

module vco_bank_top #(
    parameter int NUM_VOICES   = 4,
    parameter int CLOCK_RATE   = 50000000,
    parameter int R1           = 47000,
    parameter int R2           = 27000,
    parameter int C_35_SHIFTED = 1134
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        sample_en,
    input  logic                        cmd_strobe,
    input  audio_sample_pkg::cv_op_e    cmd_op,
    input  logic [$clog2(NUM_VOICES):0] cmd_voice,
    input  audio_sample_pkg::sample_t   cmd_value,
    output audio_sample_pkg::sample_t   mix_out,
    output logic [NUM_VOICES-1:0]       voice_gate
);

    audio_sample_pkg::sample_t [NUM_VOICES-1:0] cv_bus;
    audio_sample_pkg::sample_t [NUM_VOICES-1:0] voice_bus;
    logic [NUM_VOICES-1:0]                      voice_enable;

    cv_command_decoder #(
        .NUM_VOICES (NUM_VOICES)
    ) cv_command_decoder_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd_strobe   (cmd_strobe),
        .cmd_op       (cmd_op),
        .cmd_voice    (cmd_voice),
        .cmd_value    (cmd_value),
        .cv_bus       (cv_bus),
        .voice_enable (voice_enable)
    );

    // Every voice shares the same RC network and differs only in its control voltage.
    for (genvar v = 0; v < NUM_VOICES; v++) begin : gen_voice
        astable_555_vco #(
            .CLOCK_RATE   (CLOCK_RATE),
            .R1           (R1),
            .R2           (R2),
            .C_35_SHIFTED (C_35_SHIFTED)
        ) astable_555_vco_inst (
            .clk       (clk),
            .rst_n     (rst_n),
            .sample_en (sample_en),
            .v_control (cv_bus[v]),
            .wave_out  (voice_bus[v]),
            .gate      (voice_gate[v])
        );
    end

    voice_mixer #(
        .NUM_VOICES (NUM_VOICES)
    ) voice_mixer_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .sample_en    (sample_en),
        .voice_bus    (voice_bus),
        .voice_enable (voice_enable),
        .mix_out      (mix_out)
    );

endmodule

`default_nettype wire

/* test/vco_bank_checker.sv */
// Oscillator bank port assertions
`timescale 1ns/1ps
`default_nettype none

module vco_bank_checker #(
    parameter int NUM_VOICES = 4
) (
    input logic                      clk,
    input logic                      rst_n,
    input logic                      sample_en,
    input audio_sample_pkg::sample_t mix_out,
    input logic [NUM_VOICES-1:0]     voice_gate
);

    // One enabled high voice adds this much to the mix.
    localparam int STEP = audio_sample_pkg::HIGH_LEVEL / NUM_VOICES;

    mix_multiple: assert property (@(posedge clk) disable iff (!rst_n)
        (int'(mix_out) % STEP) == 0)
        else $error("mix_out %0d is not a multiple of %0d", mix_out, STEP);

    // The mixer loads one cycle after the strobe, so a change needs a strobe two edges back.
    mix_holds: assert property (@(posedge clk) disable iff (!rst_n)
        !$past(sample_en, 2) |-> $stable(mix_out))
        else $error("mix_out changed without a sample strobe");

    reset_zero: assert property (@(posedge clk)
        $rose(rst_n) |-> (mix_out == '0 && voice_gate == '0))
        else $error("outputs not zero after reset");

endmodule

bind vco_bank_top vco_bank_checker #(
    .NUM_VOICES (NUM_VOICES)
) vco_bank_checker_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .sample_en  (sample_en),
    .mix_out    (mix_out),
    .voice_gate (voice_gate)
);

`default_nettype wire

/* test/vco_bank_tb.sv */
// Oscillator bank testbench
`timescale 1ns/1ps
`default_nettype none

module vco_bank_tb;

    localparam int NUM_VOICES   = 4;
    localparam int CLOCK_RATE   = 1000000;
    localparam int R1           = 47000;
    localparam int R2           = 27000;
    localparam int C_35_SHIFTED = 1134;
    localparam int SAMPLE_DIV   = 8;
    localparam int STEP         = audio_sample_pkg::HIGH_LEVEL / NUM_VOICES;
    localparam int NROWS        = 13;
    // Row kinds are a plain mix check, a gate activity check and a run length check.
    localparam int K_MIX    = 0;
    localparam int K_TOGGLE = 1;
    localparam int K_RUN    = 2;

    logic                             clk;
    logic                             rst_n;
    logic                             sample_en;
    logic                             cmd_strobe;
    audio_sample_pkg::cv_op_e         cmd_op;
    logic [2:0]                       cmd_voice;
    audio_sample_pkg::sample_t        cmd_value;
    audio_sample_pkg::sample_t        mix_out;
    logic [NUM_VOICES-1:0]            voice_gate;

    audio_sample_pkg::cv_op_e  tab_op [NROWS];
    logic [2:0]                tab_voice [NROWS];
    audio_sample_pkg::sample_t tab_value [NROWS];
    int                        tab_samples [NROWS];
    int                        tab_kind [NROWS];

    int                    cv_model [NUM_VOICES];
    logic [NUM_VOICES-1:0] en_model;
    logic [31:0]           lfsr;
    logic [2:0]            phase;
    logic                  table_ready;
    longint                limit_ns;

    vco_bank_top #(
        .NUM_VOICES   (NUM_VOICES),
        .CLOCK_RATE   (CLOCK_RATE),
        .R1           (R1),
        .R2           (R2),
        .C_35_SHIFTED (C_35_SHIFTED)
    ) vco_bank_top_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .sample_en  (sample_en),
        .cmd_strobe (cmd_strobe),
        .cmd_op     (cmd_op),
        .cmd_voice  (cmd_voice),
        .cmd_value  (cmd_value),
        .mix_out    (mix_out),
        .voice_gate (voice_gate)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // The audio sample strobe is high for one clock in every SAMPLE_DIV.
    initial begin
        phase     = '0;
        sample_en = 1'b0;
        forever begin
            @(posedge clk);
            if (!rst_n) begin
                phase     <= '0;
                sample_en <= 1'b0;
            end else begin
                phase     <= phase + 1'b1;
                sample_en <= (phase == 3'(SAMPLE_DIV - 1));
            end
        end
    end

    // Fibonacci LFSR with taps 32, 22, 2 and 1 that returns one new bit per call.
    function automatic logic lfsr_bit();
        logic b;
        b    = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], b};
        return b;
    endfunction

    // Voltages whose log argument lands on a table point of the log unit.
    function automatic int cv_choice();
        int idx;
        idx = 0;
        for (int i = 0; i < 3; i++) begin
            idx = (idx << 1) | int'(lfsr_bit());
        end
        case (idx % 5)
            0:       return 8192;
            1:       return 10923;
            2:       return 14044;
            3:       return 15292;
            default: return 15856;
        endcase
    endfunction

    // The high time of the astable 555 in samples is C(R1+R2) ln(1 + v/(2(VCC-v))) f / 8.
    function automatic real high_samples(input int v);
        real c;
        real vc;
        c  = real'(C_35_SHIFTED) / (2.0 ** 35);
        vc = (v > audio_sample_pkg::CV_MAX) ? real'(audio_sample_pkg::CV_MAX) : real'(v);
        return c * (R1 + R2) * $ln(1.0 + vc / (2.0 * (audio_sample_pkg::VCC_LEVEL - vc)))
               * CLOCK_RATE / SAMPLE_DIV;
    endfunction

    // The low time in samples is C R2 ln2 f / 8 and does not depend on the control voltage.
    function automatic real low_samples();
        return real'(C_35_SHIFTED) / (2.0 ** 35) * R2 * $ln(2.0) * CLOCK_RATE / SAMPLE_DIV;
    endfunction

    function automatic int count_high(input logic [NUM_VOICES-1:0] bits);
        int n;
        n = 0;
        for (int i = 0; i < NUM_VOICES; i++) begin
            n += int'(bits[i]);
        end
        return n;
    endfunction

    task automatic report_fail(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_sample(input audio_sample_pkg::sample_t got,
                                input audio_sample_pkg::sample_t exp, input string msg);
        if (got !== exp) begin
            report_fail($sformatf("%s: got %0d expected %0d", msg, got, exp));
        end
    endtask

    task automatic check_gate(input logic [NUM_VOICES-1:0] got,
                              input logic [NUM_VOICES-1:0] exp, input string msg);
        if (got !== exp) begin
            report_fail($sformatf("%s: got %b expected %b", msg, got, exp));
        end
    endtask

    task automatic check_run(input int got, input real exp, input int tol, input string msg);
        real diff;
        diff = real'(got) - exp;
        if (diff < 0.0) begin
            diff = -diff;
        end
        if (got < 1 || diff > real'(tol)) begin
            report_fail($sformatf("%s: got %0d samples expected %0.1f", msg, got, exp));
        end
    endtask

    task automatic set_row(input int i, input audio_sample_pkg::cv_op_e op, input int voice,
                           input int value, input int samples, input int kind);
        tab_op[i]      = op;
        tab_voice[i]   = 3'(voice);
        tab_value[i]   = audio_sample_pkg::sample_t'(value);
        tab_samples[i] = samples;
        tab_kind[i]    = kind;
    endtask

    task automatic build_table();
        set_row(0, audio_sample_pkg::CV_SET, 0, 8192, 1, K_MIX);
        set_row(1, audio_sample_pkg::CV_SET, 1, cv_choice(), 1, K_MIX);
        set_row(2, audio_sample_pkg::CV_SET, 2, cv_choice(), 1, K_MIX);
        // This value lies above CV_MAX, so voice 3 must behave exactly like CV_MAX.
        set_row(3, audio_sample_pkg::CV_SET, 3, 20000, 1, K_MIX);
        set_row(4, audio_sample_pkg::CV_ALL_OFF, 0, 0, 3000, K_TOGGLE);
        set_row(5, audio_sample_pkg::CV_UNMUTE, 0, 0, 600, K_RUN);
        set_row(6, audio_sample_pkg::CV_UNMUTE, 1, 0, 8000, K_RUN);
        set_row(7, audio_sample_pkg::CV_MUTE, 0, 0, 300, K_MIX);
        // Voice 7 does not exist, so voice 3 keeps its voltage for the run check after it.
        set_row(8, audio_sample_pkg::CV_SET, 7, 100, 50, K_MIX);
        set_row(9, audio_sample_pkg::CV_UNMUTE, 3, 0, 8000, K_RUN);
        set_row(10, audio_sample_pkg::CV_SET, 2, cv_choice(), 1, K_MIX);
        set_row(11, audio_sample_pkg::CV_UNMUTE, 2, 0, 8000, K_RUN);
        set_row(12, audio_sample_pkg::CV_ALL_OFF, 0, 0, 200, K_MIX);
    endtask

    // Returns once gate and mix_out reflect the latest sample strobe.
    task automatic wait_mix();
        logic seen;
        seen = 1'b0;
        while (!seen) begin
            @(posedge clk);
            seen = sample_en;
        end
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic issue_cmd(input int row);
        int v;
        v = int'(tab_voice[row]);
        @(posedge clk);
        cmd_strobe <= 1'b1;
        cmd_op     <= tab_op[row];
        cmd_voice  <= tab_voice[row];
        cmd_value  <= tab_value[row];
        @(posedge clk);
        cmd_strobe <= 1'b0;
        case (tab_op[row])
            audio_sample_pkg::CV_SET: begin
                if (v < NUM_VOICES) begin
                    cv_model[v] = (tab_value[row] < 0) ? 0 : int'(tab_value[row]);
                end
            end
            audio_sample_pkg::CV_MUTE: if (v < NUM_VOICES) en_model[v] = 1'b0;
            audio_sample_pkg::CV_UNMUTE: if (v < NUM_VOICES) en_model[v] = 1'b1;
            default: en_model = '0;
        endcase
    endtask

    task automatic observe(input int row);
        logic [NUM_VOICES-1:0] prev;
        logic [NUM_VOICES-1:0] toggled;
        int                    v;
        int                    edges;
        int                    run;
        int                    last_high;
        int                    last_low;
        v         = int'(tab_voice[row]);
        toggled   = '0;
        edges     = 0;
        run       = 0;
        last_high = 0;
        last_low  = 0;
        for (int s = 0; s < tab_samples[row]; s++) begin
            wait_mix();
            check_sample(mix_out, audio_sample_pkg::sample_t'(count_high(voice_gate & en_model)
                         * STEP), $sformatf("mix_out in row %0d sample %0d", row, s));
            if (s > 0) begin
                toggled |= voice_gate ^ prev;
                if (tab_kind[row] == K_RUN && voice_gate[v] != prev[v]) begin
                    // The first run is partial, so only runs after the second edge count.
                    edges++;
                    if (edges >= 2) begin
                        if (prev[v]) last_high = run;
                        else last_low = run;
                    end
                    run = 0;
                end
            end
            run++;
            prev = voice_gate;
        end
        if (tab_kind[row] == K_TOGGLE) begin
            check_gate(toggled, '1, "gates toggling while muted");
        end
        if (tab_kind[row] == K_RUN) begin
            check_run(last_high, high_samples(cv_model[v]), 3,
                      $sformatf("high run of voice %0d at cv %0d", v, cv_model[v]));
            check_run(last_low, low_samples(), 2, $sformatf("low run of voice %0d", v));
        end
    endtask

    // Watchdog sized from the table's observation windows plus a margin.
    initial begin
        wait (table_ready);
        #(limit_ns);
        $display("Timeout: the run did not finish within %0d ns", limit_ns);
        $display("sim failed");
        $fatal(1);
    end

    initial begin
        rst_n       = 1'b0;
        cmd_strobe  = 1'b0;
        cmd_op      = audio_sample_pkg::CV_SET;
        cmd_voice   = '0;
        cmd_value   = '0;
        en_model    = '0;
        table_ready = 1'b0;
        lfsr        = 32'h27de_7489;
        for (int i = 0; i < NUM_VOICES; i++) begin
            cv_model[i] = 0;
        end
        build_table();
        limit_ns = 100000;
        for (int i = 0; i < NROWS; i++) begin
            limit_ns += longint'(tab_samples[i] + 2) * SAMPLE_DIV * 20;
        end
        table_ready = 1'b1;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_sample(mix_out, '0, "mix_out after reset");
        check_gate(voice_gate, '0, "voice_gate after reset");
        for (int row = 0; row < NROWS; row++) begin
            issue_cmd(row);
            observe(row);
        end
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
design/audio_sample_pkg.sv
design/rc_timing_pkg.sv
design/natural_log.sv
design/astable_555_vco.sv
design/cv_command_decoder.sv
design/voice_mixer.sv
design/vco_bank_top.sv
test/vco_bank_checker.sv
test/vco_bank_tb.sv

/* Makefile */
# Verilator build and run for the 555 oscillator bank

TOP := vco_bank_tb
LOG := sim.log

.PHONY: all build lint clean

all: build
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "sim failed" $(LOG) || ! grep -q "sim passed" $(LOG); then \
		echo "Simulation FAILED"; exit 1; \
	else \
		echo "Simulation PASSED"; \
	fi

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f filelist.f

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f filelist.f

clean:
	rm -rf obj_dir $(LOG)
